//--- files.f
src/ms6205Pkg.sv
src/displayMemory.sv
src/memArbiter.sv
src/hostAxiLite.sv
src/consoleWriter.sv
src/ms6205Scanner.sv
src/ms6205Top.sv
testbench/tbMs6205.sv

//--- src/consoleWriter.sv
`timescale 1ns/1ps
`default_nettype none

module consoleWriter (
    input  wire                       Clock_1us,
    input  wire                       rstN,
    input  wire                       Cout,
    input  wire ms6205Pkg::symbol_t   symbol,
    input  wire ms6205Pkg::view_t     currentView,
    output logic                      CioAcq,
    output logic                      memReq,
    input  wire                       memGnt,
    output ms6205Pkg::memAddr_t       memAddr,
    output ms6205Pkg::memData_t       memWdata,
    output logic                      memWe
);

    ms6205Pkg::position_t wrPtr;

    assign memReq   = Cout && !CioAcq;
    assign memAddr  = ms6205Pkg::STDIO_BASE + ms6205Pkg::memAddr_t'(wrPtr);
    assign memWdata = {4'h0, symbol};
    assign memWe    = 1'b1;   // write-only peer

    always_ff @(posedge Clock_1us) begin
        if (!rstN) begin
            CioAcq <= 1'b0;
            wrPtr  <= '0;
        end else if (memGnt) begin
            CioAcq <= 1'b1;
            if (wrPtr == ms6205Pkg::position_t'(ms6205Pkg::MAX_POS - 1)) begin
                wrPtr <= '0;
            end else begin
                wrPtr <= wrPtr + 1'b1;
            end
        end else if (!Cout && CioAcq && currentView == ms6205Pkg::VIEW_CIO) begin
            CioAcq <= 1'b0;   // release only once the console is on screen
        end
    end

endmodule

`default_nettype wire

//--- src/displayMemory.sv
`timescale 1ns/1ps
`default_nettype none

module displayMemory (
    input  wire                       Clock_1us,
    input  wire                       en,
    input  wire                       we,
    input  wire ms6205Pkg::memAddr_t  addr,
    input  wire ms6205Pkg::memData_t  wdata,
    output ms6205Pkg::memData_t       rdata
);

    ms6205Pkg::memData_t mem [0:511];

    always_ff @(posedge Clock_1us) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;
            end
            rdata <= mem[addr];   // read before write
        end
    end

endmodule

`default_nettype wire

//--- src/hostAxiLite.sv
`timescale 1ns/1ps
`default_nettype none

module hostAxiLite #(
    parameter int addrWidth = 11
) (
    input  wire                       Clock_1us,
    input  wire                       rstN,
    input  wire [31:0]                awaddr,
    input  wire                       awvalid,
    output logic                      awready,
    input  wire [31:0]                wdata,
    input  wire [3:0]                 wstrb,
    input  wire                       wvalid,
    output logic                      wready,
    output logic [1:0]                bresp,
    output logic                      bvalid,
    input  wire                       bready,
    input  wire [31:0]                araddr,
    input  wire                       arvalid,
    output logic                      arready,
    output logic [31:0]               rdata,
    output logic [1:0]                rresp,
    output logic                      rvalid,
    input  wire                       rready,
    output logic                      memReq,
    input  wire                       memGnt,
    output ms6205Pkg::memAddr_t       memAddr,
    output ms6205Pkg::memData_t       memWdata,
    output logic                      memWe,
    input  wire                       memRvalid,
    input  wire ms6205Pkg::memData_t  memRdata
);

    typedef enum logic [2:0] {
        IDLE,
        WRITE,
        BRESP,
        READ,
        RWAIT,
        RRESP
    } hostState_t;

    hostState_t state;
    logic awHave;
    logic wHave;
    logic awTake;
    logic wTake;
    logic arTake;

    // a read is only taken when no write channel is pending
    assign awready = (state == IDLE) && !awHave;
    assign wready  = (state == IDLE) && !wHave;
    assign arready = (state == IDLE) && !awHave && !wHave && !awvalid && !wvalid;

    assign awTake = awvalid && awready;
    assign wTake  = wvalid && wready;
    assign arTake = arvalid && arready;

    assign memReq = (state == WRITE) || (state == READ);
    assign memWe  = (state == WRITE);
    assign bvalid = (state == BRESP);
    assign rvalid = (state == RRESP);
    assign bresp  = 2'b00;   // OKAY
    assign rresp  = 2'b00;

    always_ff @(posedge Clock_1us) begin
        if (awTake) begin
            memAddr <= awaddr[addrWidth-1:2];
        end else if (arTake) begin
            memAddr <= araddr[addrWidth-1:2];
        end
        if (wTake) begin
            memWdata <= wdata[11:0];
        end
        if (state == RWAIT && memRvalid) begin
            rdata <= {20'd0, memRdata};
        end
    end

    always_ff @(posedge Clock_1us) begin
        if (!rstN) begin
            state  <= IDLE;
            awHave <= 1'b0;
            wHave  <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (awTake) awHave <= 1'b1;
                    if (wTake) wHave <= 1'b1;
                    if ((awHave || awTake) && (wHave || wTake)) begin
                        state <= WRITE;
                    end else if (arTake) begin
                        state <= READ;
                    end
                end
                WRITE: begin
                    if (memGnt) begin
                        awHave <= 1'b0;
                        wHave  <= 1'b0;
                        state  <= BRESP;
                    end
                end
                BRESP: if (bready) state <= IDLE;
                READ: if (memGnt) state <= RWAIT;
                RWAIT: if (memRvalid) state <= RRESP;
                RRESP: if (rready) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- src/memArbiter.sv
`timescale 1ns/1ps
`default_nettype none

module memArbiter (
    input  wire                       Clock_1us,
    input  wire                       rstN,
    input  wire                       hostReq,
    output logic                      hostGnt,
    output logic                      hostRvalid,
    input  wire ms6205Pkg::memAddr_t  hostAddr,
    input  wire ms6205Pkg::memData_t  hostWdata,
    input  wire                       hostWe,
    input  wire                       conReq,
    output logic                      conGnt,
    output logic                      conRvalid,
    input  wire ms6205Pkg::memAddr_t  conAddr,
    input  wire ms6205Pkg::memData_t  conWdata,
    input  wire                       conWe,
    input  wire                       scanReq,
    output logic                      scanGnt,
    output logic                      scanRvalid,
    input  wire ms6205Pkg::memAddr_t  scanAddr,
    input  wire ms6205Pkg::memData_t  scanWdata,
    input  wire                       scanWe,
    output logic                      memEn,
    output logic                      memWe,
    output ms6205Pkg::memAddr_t       memAddr,
    output ms6205Pkg::memData_t       memWdata
);

    logic [2:0] req;
    logic [2:0] we;
    logic [2:0] gnt;
    logic [2:0] rvalidQ;
    logic [1:0] lastWinner;

    assign req = {scanReq, conReq, hostReq};
    assign we  = {scanWe, conWe, hostWe};

    // peer after the last winner is checked first
    always_comb begin
        int idx;
        gnt = 3'b000;
        for (int k = 1; k <= 3; k++) begin
            idx = (int'(lastWinner) + k) % 3;
            if (gnt == 3'b000 && req[idx]) begin
                gnt[idx] = 1'b1;
            end
        end
    end

    assign hostGnt    = gnt[0];
    assign conGnt     = gnt[1];
    assign scanGnt    = gnt[2];
    assign hostRvalid = rvalidQ[0];
    assign conRvalid  = rvalidQ[1];
    assign scanRvalid = rvalidQ[2];

    assign memEn = |gnt;
    assign memWe = |(gnt & we);

    always_comb begin
        if (gnt[1]) begin
            memAddr  = conAddr;
            memWdata = conWdata;
        end else if (gnt[2]) begin
            memAddr  = scanAddr;
            memWdata = scanWdata;
        end else begin
            memAddr  = hostAddr;
            memWdata = hostWdata;
        end
    end

    always_ff @(posedge Clock_1us) begin
        if (!rstN) begin
            lastWinner <= 2'd2;   // host goes first
            rvalidQ    <= 3'b000;
        end else begin
            rvalidQ <= gnt & ~we;
            if (gnt[0]) begin
                lastWinner <= 2'd0;
            end else if (gnt[1]) begin
                lastWinner <= 2'd1;
            end else if (gnt[2]) begin
                lastWinner <= 2'd2;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/ms6205Pkg.sv
`default_nettype none

package ms6205Pkg;

    typedef logic [8:0]  memAddr_t;
    typedef logic [11:0] memData_t;
    typedef logic [7:0]  symbol_t;
    typedef logic [7:0]  position_t;   // row * 16 + column

    typedef enum logic [2:0] {
        VIEW_RESTART = 3'b000,
        VIEW_IRAM    = 3'b010,
        VIEW_DRAM    = 3'b011,
        VIEW_CIO     = 3'b101
    } view_t;

    localparam int COLUMNS = 16;
    localparam int ROWS    = 10;
    localparam int MAX_POS = COLUMNS * ROWS;

    // memory map
    localparam memAddr_t STDIO_BASE = 9'h000;   // 160 console cells
    localparam memAddr_t INSN_BASE  = 9'h100;   // 100 opcodes, ten per row
    localparam memAddr_t DATA_BASE  = 9'h180;   // 10 data words

    localparam symbol_t OPCODE_SYMBOLS [0:15] = '{
        " ", "+", "-", "<", ">", "[", "]", ".",
        ",", "?", "?", "?", "?", "?", "?", "?"
    };

endpackage

`default_nettype wire

//--- src/ms6205Scanner.sv
`timescale 1ns/1ps
`default_nettype none

module ms6205Scanner #(
    parameter int scanDivider = 8
) (
    input  wire                       Clock_1us,
    input  wire                       rstN,
    input  wire                       keyIram,
    input  wire                       keyDram,
    input  wire                       keyCio,
    input  wire                       keyRestart,
    input  wire                       CioAcq,
    output ms6205Pkg::view_t          currentView,
    output logic                      memReq,
    input  wire                       memGnt,
    output ms6205Pkg::memAddr_t       memAddr,
    input  wire                       memRvalid,
    input  wire ms6205Pkg::memData_t  memRdata,
    output ms6205Pkg::position_t      address,
    output ms6205Pkg::symbol_t        dataN,
    output logic                      charStrobe
);

    localparam int divWidth = (scanDivider > 1) ? $clog2(scanDivider) : 1;
    localparam logic [divWidth-1:0] divLast = divWidth'(scanDivider - 1);

    typedef enum logic [1:0] {
        IDLE,
        FETCH,
        EMIT
    } scanState_t;

    scanState_t state;
    ms6205Pkg::view_t nextView;
    ms6205Pkg::view_t cellView;
    ms6205Pkg::position_t pos;
    ms6205Pkg::memData_t word;
    ms6205Pkg::symbol_t cellSymbol;
    logic [divWidth-1:0] divCnt;
    logic [3:0] row;
    logic [3:0] col;
    logic granted;

    function automatic logic needsWord(ms6205Pkg::view_t view, logic [3:0] column);
        case (view)
            ms6205Pkg::VIEW_IRAM: needsWord = (column >= 4'd2) && (column <= 4'd11);
            ms6205Pkg::VIEW_DRAM: needsWord = (column >= 4'd3) && (column <= 4'd5);
            ms6205Pkg::VIEW_CIO:  needsWord = 1'b1;
            default:              needsWord = 1'b0;
        endcase
    endfunction

    assign row = pos[7:4];
    assign col = pos[3:0];

    always_comb begin
        if (currentView == ms6205Pkg::VIEW_RESTART) begin
            nextView = ms6205Pkg::VIEW_IRAM;
        end else if (keyIram) begin
            nextView = ms6205Pkg::VIEW_IRAM;
        end else if (keyDram) begin
            nextView = ms6205Pkg::VIEW_DRAM;
        end else if (keyCio || CioAcq) begin
            nextView = ms6205Pkg::VIEW_CIO;   // console output pulls the view over
        end else if (keyRestart) begin
            nextView = ms6205Pkg::VIEW_RESTART;
        end else begin
            nextView = currentView;
        end
    end

    always_ff @(posedge Clock_1us) begin
        if (!rstN) begin
            currentView <= ms6205Pkg::VIEW_RESTART;
        end else begin
            currentView <= nextView;
        end
    end

    // word address for the cell being built
    always_comb begin
        case (cellView)
            ms6205Pkg::VIEW_IRAM:
                memAddr = ms6205Pkg::INSN_BASE + ms6205Pkg::memAddr_t'(row) * 9'd10
                          + ms6205Pkg::memAddr_t'(col) - 9'd2;
            ms6205Pkg::VIEW_DRAM:
                memAddr = ms6205Pkg::DATA_BASE + ms6205Pkg::memAddr_t'(row);
            default:
                memAddr = ms6205Pkg::STDIO_BASE + ms6205Pkg::memAddr_t'(pos);
        endcase
    end

    assign memReq = (state == FETCH) && !granted;

    always_comb begin
        cellSymbol = " ";
        case (cellView)
            ms6205Pkg::VIEW_IRAM: begin
                if (col == 4'd0) cellSymbol = "0" + {4'h0, row};
                else if (col == 4'd1) cellSymbol = ":";
                else if (col <= 4'd11) cellSymbol = ms6205Pkg::OPCODE_SYMBOLS[word[3:0]];
            end
            ms6205Pkg::VIEW_DRAM: begin
                case (col)
                    4'd0: cellSymbol = "0" + {4'h0, row};
                    4'd1: cellSymbol = ":";
                    4'd3: cellSymbol = "0" + {4'h0, word[11:8]};
                    4'd4: cellSymbol = "0" + {4'h0, word[7:4]};
                    4'd5: cellSymbol = "0" + {4'h0, word[3:0]};
                    default: cellSymbol = " ";
                endcase
            end
            ms6205Pkg::VIEW_CIO: cellSymbol = word[7:0];
            default: cellSymbol = " ";
        endcase
    end

    always_ff @(posedge Clock_1us) begin
        if (!rstN) begin
            state      <= IDLE;
            cellView   <= ms6205Pkg::VIEW_RESTART;
            pos        <= '0;
            divCnt     <= '0;
            granted    <= 1'b0;
            charStrobe <= 1'b0;
        end else begin
            charStrobe <= 1'b0;
            case (state)
                IDLE: begin
                    divCnt <= divCnt + 1'b1;
                    if (divCnt == divLast) begin
                        divCnt   <= '0;
                        cellView <= currentView;   // view is frozen per cell
                        granted  <= 1'b0;
                        state    <= needsWord(currentView, col) ? FETCH : EMIT;
                    end
                end
                FETCH: begin
                    if (memGnt) granted <= 1'b1;
                    if (memRvalid) begin
                        word  <= memRdata;
                        state <= EMIT;
                    end
                end
                EMIT: begin
                    address    <= pos;
                    dataN      <= ~cellSymbol;   // panel takes inverted data
                    charStrobe <= 1'b1;
                    if (pos == ms6205Pkg::position_t'(ms6205Pkg::MAX_POS - 1)) begin
                        pos <= '0;
                    end else begin
                        pos <= pos + 1'b1;
                    end
                    state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- src/ms6205Top.sv
`timescale 1ns/1ps
`default_nettype none

module ms6205Top #(
    parameter int scanDivider = 8
) (
    input  wire                       Clock_1us,
    input  wire                       rstN,
    input  wire [31:0]                awaddr,
    input  wire                       awvalid,
    output logic                      awready,
    input  wire [31:0]                wdata,
    input  wire [3:0]                 wstrb,
    input  wire                       wvalid,
    output logic                      wready,
    output logic [1:0]                bresp,
    output logic                      bvalid,
    input  wire                       bready,
    input  wire [31:0]                araddr,
    input  wire                       arvalid,
    output logic                      arready,
    output logic [31:0]               rdata,
    output logic [1:0]                rresp,
    output logic                      rvalid,
    input  wire                       rready,
    input  wire                       Cout,
    input  wire ms6205Pkg::symbol_t   symbol,
    output logic                      CioAcq,
    input  wire                       keyIram,
    input  wire                       keyDram,
    input  wire                       keyCio,
    input  wire                       keyRestart,
    output ms6205Pkg::position_t      address,
    output ms6205Pkg::symbol_t        dataN,
    output logic                      charStrobe
);

    logic hostReq;
    logic hostGnt;
    logic hostRvalid;
    logic hostWe;
    ms6205Pkg::memAddr_t hostAddr;
    ms6205Pkg::memData_t hostWdata;
    logic conReq;
    logic conGnt;
    logic conWe;
    ms6205Pkg::memAddr_t conAddr;
    ms6205Pkg::memData_t conWdata;
    logic scanReq;
    logic scanGnt;
    logic scanRvalid;
    ms6205Pkg::memAddr_t scanAddr;
    logic memEn;
    logic memWe;
    ms6205Pkg::memAddr_t memAddr;
    ms6205Pkg::memData_t memWdata;
    ms6205Pkg::memData_t memRdata;
    ms6205Pkg::view_t currentView;

    memArbiter i_arbiter (
        .Clock_1us (Clock_1us),  .rstN       (rstN),
        .hostReq   (hostReq),    .hostGnt    (hostGnt),   .hostRvalid (hostRvalid),
        .hostAddr  (hostAddr),   .hostWdata  (hostWdata), .hostWe     (hostWe),
        .conReq    (conReq),     .conGnt     (conGnt),    .conRvalid  (),
        .conAddr   (conAddr),    .conWdata   (conWdata),  .conWe      (conWe),
        .scanReq   (scanReq),    .scanGnt    (scanGnt),   .scanRvalid (scanRvalid),
        .scanAddr  (scanAddr),   .scanWdata  ('0),        .scanWe     (1'b0),
        .memEn     (memEn),      .memWe      (memWe),
        .memAddr   (memAddr),    .memWdata   (memWdata)
    );

    displayMemory i_memory (
        .Clock_1us (Clock_1us),
        .en        (memEn),
        .we        (memWe),
        .addr      (memAddr),
        .wdata     (memWdata),
        .rdata     (memRdata)
    );

    hostAxiLite #(.addrWidth(11)) i_host (
        .Clock_1us (Clock_1us), .rstN     (rstN),
        .awaddr    (awaddr),    .awvalid  (awvalid),   .awready (awready),
        .wdata     (wdata),     .wstrb    (wstrb),     .wvalid  (wvalid),  .wready (wready),
        .bresp     (bresp),     .bvalid   (bvalid),    .bready  (bready),
        .araddr    (araddr),    .arvalid  (arvalid),   .arready (arready),
        .rdata     (rdata),     .rresp    (rresp),     .rvalid  (rvalid),  .rready (rready),
        .memReq    (hostReq),   .memGnt   (hostGnt),   .memAddr (hostAddr),
        .memWdata  (hostWdata), .memWe    (hostWe),
        .memRvalid (hostRvalid), .memRdata (memRdata)
    );

    consoleWriter i_console (
        .Clock_1us   (Clock_1us),
        .rstN        (rstN),
        .Cout        (Cout),
        .symbol      (symbol),
        .currentView (currentView),
        .CioAcq      (CioAcq),
        .memReq      (conReq),
        .memGnt      (conGnt),
        .memAddr     (conAddr),
        .memWdata    (conWdata),
        .memWe       (conWe)
    );

    ms6205Scanner #(.scanDivider(scanDivider)) i_scanner (
        .Clock_1us   (Clock_1us),   .rstN       (rstN),
        .keyIram     (keyIram),     .keyDram    (keyDram),
        .keyCio      (keyCio),      .keyRestart (keyRestart),
        .CioAcq      (CioAcq),      .currentView (currentView),
        .memReq      (scanReq),     .memGnt     (scanGnt),   .memAddr (scanAddr),
        .memRvalid   (scanRvalid),  .memRdata   (memRdata),
        .address     (address),     .dataN      (dataN),     .charStrobe (charStrobe)
    );

endmodule

`default_nettype wire

//--- testbench/tbMs6205.sv
`timescale 1ns/1ps
`default_nettype none

module tbMs6205;

    localparam int axiLimit   = 60;     // cycles per AXI phase
    localparam int strobeLimit = 100;   // cycles between two characters
    localparam int frameLimit = 4000;   // cycles until the frame boundary

    logic Clock_1us = 1'b0;
    logic rstN;
    logic [31:0] awaddr;
    logic awvalid;
    logic awready;
    logic [31:0] wdata;
    logic [3:0] wstrb;
    logic wvalid;
    logic wready;
    logic [1:0] bresp;
    logic bvalid;
    logic bready;
    logic [31:0] araddr;
    logic arvalid;
    logic arready;
    logic [31:0] rdata;
    logic [1:0] rresp;
    logic rvalid;
    logic rready;
    logic Cout;
    ms6205Pkg::symbol_t symbol;
    logic CioAcq;
    logic keyIram;
    logic keyDram;
    logic keyCio;
    logic keyRestart;
    ms6205Pkg::position_t address;
    ms6205Pkg::symbol_t dataN;
    logic charStrobe;

    integer seed = 54;
    logic [11:0] shadow [0:511];    // what the host and console should have stored
    logic [7:0] frame [0:159];
    int conIdx;
    logic streamStop;
    string activeTest;

    ms6205Top #(.scanDivider(2)) i_dut (
        .Clock_1us (Clock_1us), .rstN (rstN),
        .awaddr (awaddr), .awvalid (awvalid), .awready (awready),
        .wdata (wdata), .wstrb (wstrb), .wvalid (wvalid), .wready (wready),
        .bresp (bresp), .bvalid (bvalid), .bready (bready),
        .araddr (araddr), .arvalid (arvalid), .arready (arready),
        .rdata (rdata), .rresp (rresp), .rvalid (rvalid), .rready (rready),
        .Cout (Cout), .symbol (symbol), .CioAcq (CioAcq),
        .keyIram (keyIram), .keyDram (keyDram), .keyCio (keyCio), .keyRestart (keyRestart),
        .address (address), .dataN (dataN), .charStrobe (charStrobe)
    );

    always #50 Clock_1us = ~Clock_1us;

    task automatic checkValue(input string checkName, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Mismatch in %s, %s: expected 0x%0h, actual 0x%0h",
                     activeTest, checkName, expected, actual);
            $display("Simulation FAILED");
            $fatal(1, "check failed");
        end
    endtask

    task automatic reportTimeout(input string what);
        $display("Timeout: %s", what);
        $display("Simulation FAILED");
        $fatal(1, "timeout");
    endtask

    task automatic axiWrite(input logic [8:0] word, input logic [31:0] value, input int stall);
        int n;
        logic awAcc;
        logic wAcc;
        @(negedge Clock_1us);
        awaddr  = {21'd0, word, 2'b00};
        wdata   = value;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        n = 0;
        while (awvalid || wvalid) begin
            awAcc = awvalid && awready;   // ready is stable here and holds until the edge
            wAcc  = wvalid && wready;
            @(negedge Clock_1us);
            if (awAcc) awvalid = 1'b0;
            if (wAcc) wvalid = 1'b0;
            n++;
            if (n > axiLimit) reportTimeout("AXI write address or data was never accepted");
        end
        n = 0;
        while (!bvalid) begin
            @(negedge Clock_1us);
            n++;
            if (n > axiLimit) reportTimeout("AXI write response never arrived");
        end
        repeat (stall) @(negedge Clock_1us);
        checkValue("bvalid held", 1, bvalid);
        checkValue("bresp", 0, bresp);
        bready = 1'b1;
        @(negedge Clock_1us);
        bready = 1'b0;
        shadow[word] = value[11:0];
    endtask

    task automatic axiRead(input logic [8:0] word, output logic [31:0] value, input int stall);
        int n;
        logic arAcc;
        @(negedge Clock_1us);
        araddr  = {21'd0, word, 2'b00};
        arvalid = 1'b1;
        n = 0;
        while (arvalid) begin
            arAcc = arready;
            @(negedge Clock_1us);
            if (arAcc) arvalid = 1'b0;
            n++;
            if (n > axiLimit) reportTimeout("AXI read address was never accepted");
        end
        n = 0;
        while (!rvalid) begin
            @(negedge Clock_1us);
            n++;
            if (n > axiLimit) reportTimeout("AXI read data never arrived");
        end
        repeat (stall) @(negedge Clock_1us);
        checkValue("rvalid held", 1, rvalid);
        checkValue("rresp", 0, rresp);
        value  = rdata;
        rready = 1'b1;
        @(negedge Clock_1us);
        rready = 1'b0;
    endtask

    // waits for position 159, then takes one whole frame in scan order
    task automatic captureFrame();
        int n;
        n = 0;
        do begin
            @(negedge Clock_1us);
            n++;
            if (n > frameLimit) reportTimeout("no strobe at position 159");
        end while (!(charStrobe && address == 8'd159));
        for (int k = 0; k < ms6205Pkg::MAX_POS; k++) begin
            n = 0;
            do begin
                @(negedge Clock_1us);
                n++;
                if (n > strobeLimit) reportTimeout("character strobe stopped");
            end while (!charStrobe);
            checkValue("scan order", k, address);
            frame[k] = ~dataN;
        end
    endtask

    function automatic logic [7:0] expectedChar(ms6205Pkg::view_t view, int p);
        int row;
        int col;
        logic [11:0] w;
        row = p / 16;
        col = p % 16;
        expectedChar = " ";
        case (view)
            ms6205Pkg::VIEW_IRAM: begin
                if (col == 0) expectedChar = 8'h30 + 8'(row);
                else if (col == 1) expectedChar = ":";
                else if (col <= 11) begin
                    w = shadow[9'h100 + 9'(row * 10 + col - 2)];
                    expectedChar = ms6205Pkg::OPCODE_SYMBOLS[w[3:0]];
                end
            end
            ms6205Pkg::VIEW_DRAM: begin
                w = shadow[9'h180 + 9'(row)];
                if (col == 0) expectedChar = 8'h30 + 8'(row);
                else if (col == 1) expectedChar = ":";
                else if (col == 3) expectedChar = 8'h30 + {4'h0, w[11:8]};
                else if (col == 4) expectedChar = 8'h30 + {4'h0, w[7:4]};
                else if (col == 5) expectedChar = 8'h30 + {4'h0, w[3:0]};
            end
            ms6205Pkg::VIEW_CIO: expectedChar = shadow[p][7:0];
            default: expectedChar = " ";
        endcase
    endfunction

    task automatic expectFrame(input string testName, input ms6205Pkg::view_t view);
        for (int p = 0; p < ms6205Pkg::MAX_POS; p++) begin
            checkValue(testName, expectedChar(view, p), frame[p]);
        end
    endtask

    task automatic resetAndIramView();
        logic [31:0] value;
        int idx;
        activeTest = "reset and IRAM view";
        checkValue("reset charStrobe", 0, charStrobe);
        checkValue("reset CioAcq", 0, CioAcq);
        for (int i = 0; i < 512; i++) begin
            axiWrite(9'(i), 32'd0, 0);   // memory has no reset
        end
        for (int i = 0; i < 100; i++) begin
            axiWrite(9'h100 + 9'(i), $random(seed), 0);
        end
        for (int i = 0; i < 10; i++) begin
            idx = {$random(seed)} % 100;
            axiRead(9'h100 + 9'(idx), value, 0);
            checkValue("opcode readback", {20'd0, shadow[9'h100 + 9'(idx)]}, value);
        end
        captureFrame();
        expectFrame("first IRAM frame", ms6205Pkg::VIEW_IRAM);
    endtask

    task automatic randomAccess();
        logic [8:0] addrs [0:19];
        logic [31:0] value;
        activeTest = "random AXI access";
        for (int i = 0; i < 20; i++) begin
            addrs[i] = 9'h1A0 + 9'({$random(seed)} % 64);   // outside the displayed regions
            axiWrite(addrs[i], $random(seed), (i < 10) ? 0 : 1 + {$random(seed)} % 4);
            axiRead(addrs[i], value, (i < 10) ? 0 : 1 + {$random(seed)} % 4);
            checkValue("random readback", {20'd0, shadow[addrs[i]]}, value);
        end
        for (int i = 0; i < 20; i++) begin
            axiRead(addrs[i], value, 2);
            checkValue("random second read", {20'd0, shadow[addrs[i]]}, value);
        end
    endtask

    task automatic dramView();
        logic [11:0] digits;
        activeTest = "DRAM view";
        @(negedge Clock_1us);
        keyDram = 1'b1;
        @(negedge Clock_1us);
        keyDram = 1'b0;
        for (int i = 0; i < 10; i++) begin
            digits = {4'({$random(seed)} % 10), 4'({$random(seed)} % 10),
                      4'({$random(seed)} % 10)};
            axiWrite(9'h180 + 9'(i), {20'd0, digits}, 0);
        end
        captureFrame();
        expectFrame("DRAM frame", ms6205Pkg::VIEW_DRAM);
    endtask

    task automatic sendSymbol(input logic [7:0] sym);
        int n;
        @(negedge Clock_1us);
        symbol = sym;
        Cout   = 1'b1;
        n = 0;
        while (!CioAcq) begin
            @(negedge Clock_1us);
            n++;
            if (n > axiLimit) reportTimeout("CioAcq never rose for a console symbol");
        end
        shadow[conIdx] = {4'h0, sym};
        conIdx++;
        Cout = 1'b0;
        n = 0;
        while (CioAcq) begin
            @(negedge Clock_1us);
            n++;
            if (n > axiLimit) reportTimeout("CioAcq never released after Cout fell");
        end
    endtask

    task automatic consoleOutput();
        activeTest = "console output";
        for (int i = 0; i < 6; i++) begin
            sendSymbol(8'h21 + 8'({$random(seed)} % 94));   // printable ASCII
        end
        captureFrame();
        expectFrame("console frame", ms6205Pkg::VIEW_CIO);
    endtask

    task automatic restartUnderTraffic();
        int k;
        activeTest = "restart under traffic";
        streamStop = 1'b0;
        fork
            begin
                @(negedge Clock_1us);
                keyRestart = 1'b1;
                @(negedge Clock_1us);
                keyRestart = 1'b0;
                captureFrame();
                streamStop = 1'b1;
            end
            begin
                k = 0;
                while (!streamStop) begin
                    axiWrite(9'h1E0 + 9'(k % 32), $random(seed), 0);
                    k++;
                end
            end
        join
        expectFrame("IRAM after restart", ms6205Pkg::VIEW_IRAM);
    endtask

    initial begin
        rstN       = 1'b0;
        awaddr     = '0;
        awvalid    = 1'b0;
        wdata      = '0;
        wstrb      = 4'hF;
        wvalid     = 1'b0;
        bready     = 1'b0;
        araddr     = '0;
        arvalid    = 1'b0;
        rready     = 1'b0;
        Cout       = 1'b0;
        symbol     = '0;
        keyIram    = 1'b0;
        keyDram    = 1'b0;
        keyCio     = 1'b0;
        keyRestart = 1'b0;
        conIdx     = 0;
        streamStop = 1'b0;
        activeTest = "reset";
        repeat (10) @(negedge Clock_1us);
        rstN = 1'b1;
        resetAndIramView();
        randomAccess();
        dramView();
        consoleOutput();
        restartUnderTraffic();
        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire
